/* hw/rr_config.svh */
`ifndef RR_CONFIG_SVH
`define RR_CONFIG_SVH

//////////////////////////////////////////////////
// Channel beat geometry
//////////////////////////////////////////////////

// Address bits carried by one ocl/sda beat
`define RR_ADDR_W 16

// Data bits carried by one ocl/sda beat
`define RR_DATA_W 32

//////////////////////////////////////////////////
// Logging path sizing
//////////////////////////////////////////////////

// Entries held by each logger FIFO before drops start
`define RR_FIFO_DEPTH 4

// Entry index width inside one storage region
`define RR_REGION_W 6

`endif

/* hw/rr_pkg.sv */
`default_nettype none

`include "rr_config.svh"

package rr_pkg;

  //////////////////////////////////////////////////
  // Channel and log entry formats
  //////////////////////////////////////////////////

  // One beat on an ocl or sda channel
  typedef struct packed {
    logic                  valid;
    logic [`RR_ADDR_W-1:0] addr;
    logic [`RR_DATA_W-1:0] data;
  } rr_beat_t;

  // Merged log entry, mask bit 0 is ocl and bit 1 is sda
  // Fields of a channel that was idle are zero
  typedef struct packed {
    logic [1:0]            mask;
    logic [`RR_ADDR_W-1:0] ocl_addr;
    logic [`RR_DATA_W-1:0] ocl_data;
    logic [`RR_ADDR_W-1:0] sda_addr;
    logic [`RR_DATA_W-1:0] sda_data;
  } rr_entry_t;

  // Log stream, also picks the storage region
  typedef enum logic {
    STREAM_RECORD   = 1'b0,
    STREAM_VALIDATE = 1'b1
  } rr_stream_e;

  // One write toward the trace storage
  typedef struct packed {
    logic                    valid;
    rr_stream_e              stream;
    logic [`RR_REGION_W-1:0] index;
    rr_entry_t               entry;
  } rr_mem_wr_t;

  //////////////////////////////////////////////////
  // Register port
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_MODE    = 2'd0,
    CSR_STATE   = 2'd1,
    CSR_REC_CNT = 2'd2,
    CSR_VAL_CNT = 2'd3
  } rr_csr_addr_e;

  typedef struct packed {
    logic         valid;
    logic         write;
    rr_csr_addr_e addr;
    logic [31:0]  data;
  } rr_cfg_req_t;

  // Mode bits, record_en sits in bit 0 and validate_en in bit 1
  typedef struct packed {
    logic validate_en;
    logic record_en;
  } rr_mode_t;

endpackage

`default_nettype wire

/* hw/rr_csrs.sv */
`default_nettype none

module rr_csrs (
  input  wire                  clk,
  input  wire                  rstn,
  input  rr_pkg::rr_cfg_req_t  i_cfg,
  input  wire                  i_rec_overflow,
  input  wire                  i_val_overflow,
  input  wire                  i_rec_accept,
  input  wire                  i_val_accept,
  output rr_pkg::rr_mode_t     o_mode,
  output logic [31:0]          o_cfg_rdata,
  output logic                 o_cfg_rvalid
);
  import rr_pkg::*;

  rr_mode_t    mode_q;
  // Sticky FIFO overflow flags, bit 0 record and bit 1 validate
  logic [1:0]  state_q;
  logic [31:0] rec_cnt_q;
  logic [31:0] val_cnt_q;
  logic [31:0] rd_word;
  logic        wr_en;
  logic        rd_en;

  assign wr_en = i_cfg.valid && i_cfg.write;
  assign rd_en = i_cfg.valid && !i_cfg.write;

  //////////////////////////////////////////////////
  // Register updates
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode_q    <= '0;
      state_q   <= '0;
      rec_cnt_q <= '0;
      val_cnt_q <= '0;
    end else begin
      // Mode loads from the low two data bits
      if (wr_en && i_cfg.addr == CSR_MODE) begin
        mode_q <= rr_mode_t'(i_cfg.data[1:0]);
      end
      // Any write clears, pulses in the same cycle still land
      if (wr_en && i_cfg.addr == CSR_STATE) begin
        state_q <= {i_val_overflow, i_rec_overflow};
      end else begin
        state_q <= state_q | {i_val_overflow, i_rec_overflow};
      end
      // Counters wrap at 32 bits, host writes ignored
      if (i_rec_accept) begin
        rec_cnt_q <= rec_cnt_q + 32'd1;
      end
      if (i_val_accept) begin
        val_cnt_q <= val_cnt_q + 32'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read path, one cycle
  //////////////////////////////////////////////////

  always_comb begin
    case (i_cfg.addr)
      CSR_MODE:    rd_word = {30'd0, mode_q};
      CSR_STATE:   rd_word = {30'd0, state_q};
      CSR_REC_CNT: rd_word = rec_cnt_q;
      CSR_VAL_CNT: rd_word = val_cnt_q;
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_cfg_rvalid <= 1'b0;
    end else begin
      o_cfg_rvalid <= rd_en;
    end
  end

  // Read data captured along with the request
  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_cfg_rdata <= rd_word;
    end
  end

  assign o_mode = mode_q;

  // One storage write per cycle, so at most one counter moves
  a_single_accept: assert property (
    @(posedge clk) disable iff (!rstn)
    !(i_rec_accept && i_val_accept)
  ) else $error("both entry counters advanced in one cycle");

endmodule

`default_nettype wire

/* hw/rr_channel_logger.sv */
`default_nettype none

`include "rr_config.svh"

module rr_channel_logger (
  input  wire                clk,
  input  wire                rstn,
  input  wire                i_en,
  input  rr_pkg::rr_beat_t   i_ch0,
  input  rr_pkg::rr_beat_t   i_ch1,
  input  wire                i_pop,
  output rr_pkg::rr_entry_t  o_entry,
  output logic               o_entry_valid,
  output logic               o_overflow
);
  import rr_pkg::*;

  localparam int PTR_W = $clog2(`RR_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`RR_FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`RR_FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`RR_FIFO_DEPTH);

  rr_entry_t        mem [`RR_FIFO_DEPTH];
  rr_entry_t        entry_in;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             sample;
  logic             full;
  logic             push;

  //////////////////////////////////////////////////
  // Merge both channels into one entry
  //////////////////////////////////////////////////

  // Any valid beat while enabled makes an entry
  assign sample = i_en && (i_ch0.valid || i_ch1.valid);
  assign full   = (count == FULL_CNT);
  assign push   = sample && !full;

  always_comb begin
    entry_in      = '0;
    entry_in.mask = {i_ch1.valid, i_ch0.valid};
    // ocl goes in slot 0
    if (i_ch0.valid) begin
      entry_in.ocl_addr = i_ch0.addr;
      entry_in.ocl_data = i_ch0.data;
    end
    // sda goes in slot 1
    if (i_ch1.valid) begin
      entry_in.sda_addr = i_ch1.addr;
      entry_in.sda_data = i_ch1.data;
    end
  end

  //////////////////////////////////////////////////
  // Circular FIFO
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= entry_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Entry dropped on a full FIFO, flag it for one cycle
      o_overflow <= sample && full;
    end
  end

  // Head entry, visible the cycle after its push
  assign o_entry       = mem[rd_ptr];
  assign o_entry_valid = (count != '0);

  // Arbiter must only pop a logger that reports an entry
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rstn)
    i_pop |-> count != '0
  ) else $error("logger FIFO popped while empty");

endmodule

`default_nettype wire

/* hw/rr_log_arbiter.sv */
`default_nettype none

`include "rr_config.svh"

module rr_log_arbiter (
  input  wire                clk,
  input  wire                rstn,
  input  rr_pkg::rr_entry_t  i_rec_entry,
  input  rr_pkg::rr_entry_t  i_val_entry,
  input  wire                i_rec_valid,
  input  wire                i_val_valid,
  input  wire                i_mem_ready,
  output logic               o_rec_pop,
  output logic               o_val_pop,
  output rr_pkg::rr_mem_wr_t o_mem_wr
);
  import rr_pkg::*;

  // Priority stream, also the locked stream during a stall
  rr_stream_e              grant_q;
  logic                    hold_q;
  rr_stream_e              sel;
  logic [`RR_REGION_W-1:0] rec_idx_q;
  logic [`RR_REGION_W-1:0] val_idx_q;
  logic                    accept;

  //////////////////////////////////////////////////
  // Stream selection
  //////////////////////////////////////////////////

  always_comb begin
    if (hold_q || (i_rec_valid && i_val_valid)) begin
      sel = grant_q;
    end else if (i_rec_valid) begin
      sel = STREAM_RECORD;
    end else begin
      sel = STREAM_VALIDATE;
    end
  end

  // Head entries only move on a pop, so the write stays put while stalled
  always_comb begin
    o_mem_wr.valid  = i_rec_valid || i_val_valid;
    o_mem_wr.stream = sel;
    if (sel == STREAM_RECORD) begin
      o_mem_wr.index = rec_idx_q;
      o_mem_wr.entry = i_rec_entry;
    end else begin
      o_mem_wr.index = val_idx_q;
      o_mem_wr.entry = i_val_entry;
    end
  end

  assign accept    = o_mem_wr.valid && i_mem_ready;
  assign o_rec_pop = accept && (sel == STREAM_RECORD);
  assign o_val_pop = accept && (sel == STREAM_VALIDATE);

  //////////////////////////////////////////////////
  // Grant and region pointers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      grant_q   <= STREAM_RECORD;
      hold_q    <= 1'b0;
      rec_idx_q <= '0;
      val_idx_q <= '0;
    end else begin
      hold_q <= o_mem_wr.valid && !i_mem_ready;
      if (accept) begin
        // Hand priority to the other stream
        grant_q <= (sel == STREAM_RECORD) ? STREAM_VALIDATE : STREAM_RECORD;
      end else if (o_mem_wr.valid) begin
        grant_q <= sel;
      end
      // Indices wrap at the region size
      if (o_rec_pop) begin
        rec_idx_q <= rec_idx_q + 1'b1;
      end
      if (o_val_pop) begin
        val_idx_q <= val_idx_q + 1'b1;
      end
    end
  end

  a_mem_wr_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    (o_mem_wr.valid && !i_mem_ready) |=> $stable(o_mem_wr)
  ) else $error("storage write changed while stalled");

endmodule

`default_nettype wire

/* hw/rr_wrapper.sv */
`default_nettype none

module rr_wrapper (
  input  wire                 clk,
  input  wire                 rstn,
  input  rr_pkg::rr_beat_t    i_sh_ocl,
  input  rr_pkg::rr_beat_t    i_sh_sda,
  input  rr_pkg::rr_beat_t    i_cl_ocl,
  input  rr_pkg::rr_beat_t    i_cl_sda,
  input  rr_pkg::rr_cfg_req_t i_cfg,
  input  wire                 i_mem_ready,
  output rr_pkg::rr_beat_t    o_cl_ocl,
  output rr_pkg::rr_beat_t    o_cl_sda,
  output rr_pkg::rr_beat_t    o_sh_ocl,
  output rr_pkg::rr_beat_t    o_sh_sda,
  output logic [31:0]         o_cfg_rdata,
  output logic                o_cfg_rvalid,
  output rr_pkg::rr_mem_wr_t  o_mem_wr
);
  import rr_pkg::*;

  rr_mode_t  mode;
  rr_entry_t rec_entry;
  rr_entry_t val_entry;
  logic      rec_valid;
  logic      val_valid;
  logic      rec_pop;
  logic      val_pop;
  logic      rec_overflow;
  logic      val_overflow;

  //////////////////////////////////////////////////
  // Host and user circuit passthrough
  //////////////////////////////////////////////////

  // Requests toward the user circuit
  assign o_cl_ocl = i_sh_ocl;
  assign o_cl_sda = i_sh_sda;
  // Responses back to the host
  assign o_sh_ocl = i_cl_ocl;
  assign o_sh_sda = i_cl_sda;

  //////////////////////////////////////////////////
  // Logging path
  //////////////////////////////////////////////////

  // Record side sees host-to-user traffic
  rr_channel_logger u_record_logger (
    .clk           (clk),
    .rstn          (rstn),
    .i_en          (mode.record_en),
    .i_ch0         (i_sh_ocl),
    .i_ch1         (i_sh_sda),
    .i_pop         (rec_pop),
    .o_entry       (rec_entry),
    .o_entry_valid (rec_valid),
    .o_overflow    (rec_overflow)
  );

  // Validate side sees the user circuit responses
  rr_channel_logger u_validate_logger (
    .clk           (clk),
    .rstn          (rstn),
    .i_en          (mode.validate_en),
    .i_ch0         (i_cl_ocl),
    .i_ch1         (i_cl_sda),
    .i_pop         (val_pop),
    .o_entry       (val_entry),
    .o_entry_valid (val_valid),
    .o_overflow    (val_overflow)
  );

  rr_log_arbiter u_log_arbiter (
    .clk         (clk),
    .rstn        (rstn),
    .i_rec_entry (rec_entry),
    .i_val_entry (val_entry),
    .i_rec_valid (rec_valid),
    .i_val_valid (val_valid),
    .i_mem_ready (i_mem_ready),
    .o_rec_pop   (rec_pop),
    .o_val_pop   (val_pop),
    .o_mem_wr    (o_mem_wr)
  );

  // A pop is exactly one accepted storage write
  rr_csrs u_csrs (
    .clk            (clk),
    .rstn           (rstn),
    .i_cfg          (i_cfg),
    .i_rec_overflow (rec_overflow),
    .i_val_overflow (val_overflow),
    .i_rec_accept   (rec_pop),
    .i_val_accept   (val_pop),
    .o_mode         (mode),
    .o_cfg_rdata    (o_cfg_rdata),
    .o_cfg_rvalid   (o_cfg_rvalid)
  );

endmodule

`default_nettype wire

/* tb/tb_rr_wrapper.sv */
`default_nettype none

`include "rr_config.svh"

module tb_rr_wrapper;
  timeunit 1ns;
  timeprecision 100ps;
  import rr_pkg::*;

  logic        clk = 1'b0;
  logic        rstn;
  rr_beat_t    sh_ocl;
  rr_beat_t    sh_sda;
  rr_beat_t    cl_ocl;
  rr_beat_t    cl_sda;
  rr_cfg_req_t cfg;
  logic        mem_ready;
  rr_beat_t    o_cl_ocl;
  rr_beat_t    o_cl_sda;
  rr_beat_t    o_sh_ocl;
  rr_beat_t    o_sh_sda;
  logic [31:0] o_cfg_rdata;
  logic        o_cfg_rvalid;
  rr_mem_wr_t  o_mem_wr;

  integer seed = 32'h2216_fc1e;

  // Reference model, only the monitor updates it
  rr_entry_t               rec_q[$];
  rr_entry_t               val_q[$];
  logic [`RR_REGION_W-1:0] rec_idx = '0;
  logic [`RR_REGION_W-1:0] val_idx = '0;
  logic [31:0]             rec_cnt = '0;
  logic [31:0]             val_cnt = '0;
  rr_mode_t                model_mode = '0;
  logic [1:0]              model_state = '0;

  // Error counts by kind
  int unsigned word_mismatches = 0;
  int unsigned wait_errors = 0;
  int unsigned stream_mismatches = 0;
  int unsigned stream_errors = 0;

  always #4 clk = ~clk;

  rr_wrapper u_rr_wrapper (
    .clk          (clk),
    .rstn         (rstn),
    .i_sh_ocl     (sh_ocl),
    .i_sh_sda     (sh_sda),
    .i_cl_ocl     (cl_ocl),
    .i_cl_sda     (cl_sda),
    .i_cfg        (cfg),
    .i_mem_ready  (mem_ready),
    .o_cl_ocl     (o_cl_ocl),
    .o_cl_sda     (o_cl_sda),
    .o_sh_ocl     (o_sh_ocl),
    .o_sh_sda     (o_sh_sda),
    .o_cfg_rdata  (o_cfg_rdata),
    .o_cfg_rvalid (o_cfg_rvalid),
    .o_mem_wr     (o_mem_wr)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_beat(input string name, input rr_beat_t exp, input rr_beat_t act);
    if (exp !== act) begin
      stream_mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_entry(input string name, input rr_mem_wr_t exp, input rr_mem_wr_t act);
    if (exp !== act) begin
      stream_mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      word_mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic random_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // Payload stays random on idle beats so the zero fill gets exercised
  function automatic rr_beat_t random_beat(input logic valid);
    rr_beat_t b;
    b.valid = valid;
    b.addr  = `RR_ADDR_W'($random(seed));
    b.data  = `RR_DATA_W'($random(seed));
    return b;
  endfunction

  // Packing rule, ocl in slot 0 and sda in slot 1, idle slots zero
  function automatic rr_entry_t pack_entry(input rr_beat_t ocl, input rr_beat_t sda);
    rr_entry_t e;
    e      = '0;
    e.mask = {sda.valid, ocl.valid};
    if (ocl.valid) begin
      e.ocl_addr = ocl.addr;
      e.ocl_data = ocl.data;
    end
    if (sda.valid) begin
      e.sda_addr = sda.addr;
      e.sda_data = sda.data;
    end
    return e;
  endfunction

  // All tasks start and end 1 ns after a rising edge
  task automatic drive_beats(input logic sh_on, input logic cl_on);
    sh_ocl = random_beat(sh_on & random_bit());
    sh_sda = random_beat(sh_on & random_bit());
    cl_ocl = random_beat(cl_on & random_bit());
    cl_sda = random_beat(cl_on & random_bit());
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input rr_csr_addr_e addr, input logic [31:0] data);
    cfg.valid = 1'b1;
    cfg.write = 1'b1;
    cfg.addr  = addr;
    cfg.data  = data;
    @(posedge clk);
    #1;
    cfg.valid = 1'b0;
  endtask

  // Response must show up right after the edge that took the request
  task automatic read_reg(input rr_csr_addr_e addr, output logic [31:0] data);
    int unsigned cycles;
    cycles    = 0;
    cfg.valid = 1'b1;
    cfg.write = 1'b0;
    cfg.addr  = addr;
    cfg.data  = '0;
    @(posedge clk);
    #1;
    cfg.valid = 1'b0;
    while (!o_cfg_rvalid && cycles < 8) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!o_cfg_rvalid) begin
      wait_errors++;
      $display("Register read of address %0d got no response", addr);
    end else if (cycles != 0) begin
      wait_errors++;
      $display("Register read response came %0d cycles late", cycles);
    end
    data = o_cfg_rdata;
  endtask

  // Sparse beats, at least 3 idle cycles between bursts
  task automatic run_traffic(input int unsigned cycles, input logic cl_on);
    int unsigned gap;
    gap = 3;
    for (int unsigned i = 0; i < cycles; i++) begin
      // Force ready before a queue can reach the FIFO depth
      if (rec_q.size() >= `RR_FIFO_DEPTH - 1 || val_q.size() >= `RR_FIFO_DEPTH - 1) begin
        mem_ready = 1'b1;
      end else begin
        mem_ready = random_bit() | random_bit();
      end
      if (gap >= 3 && random_bit()) begin
        drive_beats(1'b1, cl_on);
        gap = 0;
      end else begin
        drive_beats(1'b0, 1'b0);
        gap++;
      end
    end
    drive_beats(1'b0, 1'b0);
  endtask

  task automatic drain();
    int unsigned cycles;
    cycles    = 0;
    mem_ready = 1'b1;
    while ((rec_q.size() != 0 || val_q.size() != 0 || o_mem_wr.valid) && cycles < 100) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (rec_q.size() != 0 || val_q.size() != 0 || o_mem_wr.valid) begin
      wait_errors++;
      $display("Drain timed out with %0d record and %0d validate entries pending",
               rec_q.size(), val_q.size());
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and reference model
  //////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    rr_mem_wr_t exp_wr;
    rr_mem_wr_t held_wr;
    logic       stalled;
    logic       rec_full;
    logic       val_full;
    if (!rstn) begin
      stalled = 1'b0;
    end else begin
      check_beat("pass_cl_ocl", sh_ocl, o_cl_ocl);
      check_beat("pass_cl_sda", sh_sda, o_cl_sda);
      check_beat("pass_sh_ocl", cl_ocl, o_sh_ocl);
      check_beat("pass_sh_sda", cl_sda, o_sh_sda);
      // Write must hold while the previous cycle stalled
      if (stalled) begin
        check_entry("stall_hold", held_wr, o_mem_wr);
      end
      stalled = o_mem_wr.valid && !mem_ready;
      held_wr = o_mem_wr;
      // Fullness is judged before this edge's pop
      rec_full = (rec_q.size() == `RR_FIFO_DEPTH);
      val_full = (val_q.size() == `RR_FIFO_DEPTH);
      if (o_mem_wr.valid && mem_ready) begin
        exp_wr        = '0;
        exp_wr.valid  = 1'b1;
        exp_wr.stream = o_mem_wr.stream;
        if (o_mem_wr.stream == STREAM_RECORD) begin
          if (rec_q.size() == 0) begin
            stream_errors++;
            $display("Record write accepted with no record entry expected");
          end else begin
            exp_wr.index = rec_idx;
            exp_wr.entry = rec_q.pop_front();
            check_entry("record_write", exp_wr, o_mem_wr);
          end
          rec_idx = rec_idx + `RR_REGION_W'(1);
        end else begin
          if (val_q.size() == 0) begin
            stream_errors++;
            $display("Validate write accepted with no validate entry expected");
          end else begin
            exp_wr.index = val_idx;
            exp_wr.entry = val_q.pop_front();
            check_entry("validate_write", exp_wr, o_mem_wr);
          end
          val_idx = val_idx + `RR_REGION_W'(1);
        end
      end
      // Loggers sample with the mode that was in force before this edge
      if (model_mode.record_en && (sh_ocl.valid || sh_sda.valid)) begin
        if (rec_full) begin
          model_state[0] = 1'b1;
        end else begin
          rec_q.push_back(pack_entry(sh_ocl, sh_sda));
          rec_cnt = rec_cnt + 32'd1;
        end
      end
      if (model_mode.validate_en && (cl_ocl.valid || cl_sda.valid)) begin
        if (val_full) begin
          model_state[1] = 1'b1;
        end else begin
          val_q.push_back(pack_entry(cl_ocl, cl_sda));
          val_cnt = val_cnt + 32'd1;
        end
      end
      if (cfg.valid && cfg.write && cfg.addr == CSR_MODE) begin
        model_mode.record_en   = cfg.data[0];
        model_mode.validate_en = cfg.data[1];
      end
      if (cfg.valid && cfg.write && cfg.addr == CSR_STATE) begin
        model_state = 2'b00;
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rd;
    int unsigned polls;
    rstn      = 1'b0;
    sh_ocl    = '0;
    sh_sda    = '0;
    cl_ocl    = '0;
    cl_sda    = '0;
    cfg       = '0;
    mem_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;

    // Dense random beats with logging off
    for (int i = 0; i < 40; i++) begin
      drive_beats(1'b1, 1'b1);
    end
    drive_beats(1'b0, 1'b0);

    // Record only, validate side must stay silent
    write_reg(CSR_MODE, 32'd1);
    run_traffic(120, 1'b1);
    drain();
    read_reg(CSR_VAL_CNT, rd);
    check_word("val_cnt_gated", 32'd0, rd);
    read_reg(CSR_REC_CNT, rd);
    check_word("rec_cnt_gated", rec_cnt, rd);

    // Both streams with random stalls
    write_reg(CSR_MODE, 32'd3);
    run_traffic(300, 1'b1);
    drain();
    read_reg(CSR_REC_CNT, rd);
    check_word("rec_cnt", rec_cnt, rd);
    read_reg(CSR_VAL_CNT, rd);
    check_word("val_cnt", val_cnt, rd);
    read_reg(CSR_STATE, rd);
    check_word("state_no_overflow", 32'd0, rd);

    // Overflow the record FIFO with storage blocked
    write_reg(CSR_MODE, 32'd1);
    mem_ready = 1'b0;
    for (int i = 0; i < `RR_FIFO_DEPTH + 2; i++) begin
      sh_ocl = random_beat(1'b1);
      sh_sda = random_beat(random_bit());
      @(posedge clk);
      #1;
    end
    drive_beats(1'b0, 1'b0);
    polls = 0;
    rd    = '0;
    while (!rd[0] && polls < 6) begin
      read_reg(CSR_STATE, rd);
      polls++;
    end
    if (!rd[0]) begin
      wait_errors++;
      $display("Record overflow flag never set");
    end
    check_word("state_overflow", {30'd0, model_state}, rd);
    write_reg(CSR_STATE, 32'd0);
    read_reg(CSR_STATE, rd);
    check_word("state_cleared", 32'd0, rd);
    drain();
    read_reg(CSR_REC_CNT, rd);
    check_word("rec_cnt_final", rec_cnt, rd);

    $display("Register mismatches %0d, stream mismatches %0d, stream errors %0d, waits failed %0d",
             word_mismatches, stream_mismatches, stream_errors, wait_errors);
    if (word_mismatches == 0 && stream_mismatches == 0 && stream_errors == 0 &&
        wait_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/rr_pkg.sv
hw/rr_csrs.sv
hw/rr_channel_logger.sv
hw/rr_log_arbiter.sv
hw/rr_wrapper.sv
tb/tb_rr_wrapper.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_rr_wrapper \
  -f verilog.f \
  -o tb_rr_wrapper

./obj_dir/tb_rr_wrapper | tee sim.log

if grep -q "test failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
